// ==== hdl/load_pkg.sv ====
/*
 * Shared load stage definitions
 *   Width constants for elements, tiles, addresses and buffer ids
 *   Command opcode enum and command struct
 *   Tile union with raw and element views
 *   DRAM request/response and buffer write structs
 */
package load_pkg;

    // Element and tile geometry
    parameter int DATA_WIDTH   = 8;
    parameter int TILE_WIDTH   = 256;
    parameter int TILE_ELEMS   = TILE_WIDTH / DATA_WIDTH;
    // DRAM tile address and buffer addressing
    parameter int ADDR_WIDTH   = 24;
    parameter int BUF_ID_WIDTH = 5;
    // Tile index inside a buffer, also wide enough for the row count
    parameter int INDEX_WIDTH  = 10;

    // Host opcodes, every other value is rejected
    typedef enum logic [4:0] {
        OP_LOAD_V = 5'd1,
        OP_LOAD_M = 5'd2
    } opcode_t;

    typedef logic signed [DATA_WIDTH-1:0] elem_t;

    // One DRAM word, matrix rows use raw bits, vectors use elements
    // Element 0 sits in the low bits
    typedef union packed {
        logic [TILE_WIDTH-1:0]   raw;
        elem_t [TILE_ELEMS-1:0]  elem;
    } tile_u;

    typedef struct packed {
        opcode_t                 opcode;
        logic [BUF_ID_WIDTH-1:0] dest_buffer;
        logic [ADDR_WIDTH-1:0]   addr;
        logic [9:0]              length_or_cols;
        logic [9:0]              rows;
    } load_cmd_t;

    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        tile_u data;
    } mem_rsp_t;

    typedef struct packed {
        logic                    en;
        logic [BUF_ID_WIDTH-1:0] buffer_id;
        logic [INDEX_WIDTH-1:0]  index;
        tile_u                   tile;
    } buf_wr_t;

endpackage

// ==== hdl/load_v.sv ====
/*
 * Vector load engine
 *   Issues one tile read per cycle while credits allow
 *   Writes each response to the next tile index
 *   Zeroes elements past the vector length in the last tile
 */
`timescale 1ns/1ps

module load_v import load_pkg::*; #(
    parameter int TILE_ELEMS = load_pkg::TILE_ELEMS,
    parameter int ADDR_WIDTH = load_pkg::ADDR_WIDTH
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic [ADDR_WIDTH-1:0]  addr,
    input  logic [9:0]             length,
    input  logic                   issue_ok,
    output mem_req_t               req,
    input  mem_rsp_t               rsp,
    output logic                   wr_valid,
    output logic [INDEX_WIDTH-1:0] wr_index,
    output tile_u                  wr_tile,
    output logic                   finished
);

    logic                   active;
    logic [INDEX_WIDTH-1:0] issue_cnt;
    logic [INDEX_WIDTH-1:0] rsp_cnt;
    logic [INDEX_WIDTH:0]   len_round;
    logic [INDEX_WIDTH-1:0] n_tiles;
    logic                   last_rsp;

    // Tile count, length rounded up to whole tiles
    assign len_round = {1'b0, length} + (INDEX_WIDTH+1)'(TILE_ELEMS - 1);
    assign n_tiles   = INDEX_WIDTH'(len_round / (INDEX_WIDTH+1)'(TILE_ELEMS));

    // Request the next tile while any are left and a credit is free
    assign req.valid = active && (issue_cnt != n_tiles) && issue_ok;
    assign req.addr  = addr + ADDR_WIDTH'(issue_cnt);

    // Responses arrive in order, so the count is the tile index
    assign wr_valid = active && rsp.valid;
    assign wr_index = rsp_cnt;
    assign last_rsp = wr_valid && (rsp_cnt == n_tiles - 1'b1);

    // Elements whose global position reaches length are cleared
    // Only the final tile can hold such positions
    always_comb begin
        wr_tile = rsp.data;
        for (int e = 0; e < TILE_ELEMS; e++) begin
            if (int'(rsp_cnt) * TILE_ELEMS + e >= int'(length)) begin
                wr_tile.elem[e] = '0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active    <= 1'b0;
            issue_cnt <= '0;
            rsp_cnt   <= '0;
            finished  <= 1'b0;
        end else begin
            finished <= 1'b0;
            if (start) begin
                // Empty vector finishes right away
                active    <= (n_tiles != '0);
                finished  <= (n_tiles == '0);
                issue_cnt <= '0;
                rsp_cnt   <= '0;
            end else if (active) begin
                if (req.valid) begin
                    issue_cnt <= issue_cnt + 1'b1;
                end
                if (wr_valid) begin
                    rsp_cnt <= rsp_cnt + 1'b1;
                end
                // Finish pulse lands the cycle after the last write
                if (last_rsp) begin
                    active   <= 1'b0;
                    finished <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== hdl/load_m.sv ====
/*
 * Matrix load engine
 *   Issues one tile read per row while credits allow
 *   Writes row r to tile index r
 *   Clears columns at or past the column count in every row
 */
`timescale 1ns/1ps

module load_m import load_pkg::*; #(
    parameter int TILE_ELEMS = load_pkg::TILE_ELEMS,
    parameter int ADDR_WIDTH = load_pkg::ADDR_WIDTH
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic [ADDR_WIDTH-1:0]  addr,
    input  logic [9:0]             rows,
    input  logic [9:0]             cols,
    input  logic                   issue_ok,
    output mem_req_t               req,
    input  mem_rsp_t               rsp,
    output logic                   wr_valid,
    output logic [INDEX_WIDTH-1:0] wr_index,
    output tile_u                  wr_tile,
    output logic                   finished
);

    logic                   active;
    logic [INDEX_WIDTH-1:0] issue_cnt;
    logic [INDEX_WIDTH-1:0] rsp_cnt;
    logic                   last_rsp;
    tile_u                  keep;

    // One row per tile, rows issued back to back
    assign req.valid = active && (issue_cnt != rows) && issue_ok;
    assign req.addr  = addr + ADDR_WIDTH'(issue_cnt);

    assign wr_valid = active && rsp.valid;
    assign wr_index = rsp_cnt;
    assign last_rsp = wr_valid && (rsp_cnt == rows - 1'b1);

    // Column mask built per element, applied on the raw bits
    // cols of a full tile or more keeps every element
    always_comb begin
        for (int e = 0; e < TILE_ELEMS; e++) begin
            keep.elem[e] = (e < int'(cols)) ? '1 : '0;
        end
    end

    assign wr_tile.raw = rsp.data.raw & keep.raw;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active    <= 1'b0;
            issue_cnt <= '0;
            rsp_cnt   <= '0;
            finished  <= 1'b0;
        end else begin
            finished <= 1'b0;
            if (start) begin
                // Zero rows means nothing to fetch
                active    <= (rows != '0);
                finished  <= (rows == '0);
                issue_cnt <= '0;
                rsp_cnt   <= '0;
            end else if (active) begin
                if (req.valid) begin
                    issue_cnt <= issue_cnt + 1'b1;
                end
                if (wr_valid) begin
                    rsp_cnt <= rsp_cnt + 1'b1;
                end
                if (last_rsp) begin
                    active   <= 1'b0;
                    finished <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== hdl/load_execution.sv ====
/*
 * Load command control
 *   Command FSM with opcode decode and reject path
 *   DRAM request credit counter
 *   Response routing to the active engine
 *   Request and buffer write muxing from both engines
 */
`timescale 1ns/1ps

module load_execution import load_pkg::*; #(
    parameter int MEM_CREDITS = 4,
    parameter int TILE_ELEMS  = load_pkg::TILE_ELEMS,
    parameter int ADDR_WIDTH  = load_pkg::ADDR_WIDTH
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      cmd_valid,
    input  load_cmd_t cmd,
    output logic      busy,
    output logic      done,
    output logic      cmd_err,
    output mem_req_t  mem_req,
    input  logic      mem_credit,
    input  mem_rsp_t  mem_rsp,
    output buf_wr_t   buf_wr
);

    localparam int CRED_W = $clog2(MEM_CREDITS + 1);

    typedef enum logic [1:0] {
        IDLE,
        LOADING_VECTOR,
        LOADING_MATRIX,
        COMPLETE
    } state_t;

    state_t                 state;
    load_cmd_t              cmd_q;
    logic [CRED_W-1:0]      credits;
    logic                   v_start;
    logic                   m_start;
    logic                   v_issue_ok;
    logic                   m_issue_ok;
    mem_req_t               v_req;
    mem_req_t               m_req;
    mem_rsp_t               v_rsp;
    mem_rsp_t               m_rsp;
    logic                   v_wr_valid;
    logic                   m_wr_valid;
    logic [INDEX_WIDTH-1:0] v_wr_index;
    logic [INDEX_WIDTH-1:0] m_wr_index;
    tile_u                  v_wr_tile;
    tile_u                  m_wr_tile;
    logic                   v_finished;
    logic                   m_finished;

    assign busy = (state != IDLE);

    // Only the engine that owns the command may spend credits
    assign v_issue_ok = (state == LOADING_VECTOR) && (credits != '0);
    assign m_issue_ok = (state == LOADING_MATRIX) && (credits != '0);

    // Response goes only to the active engine
    always_comb begin
        v_rsp       = mem_rsp;
        m_rsp       = mem_rsp;
        v_rsp.valid = mem_rsp.valid && (state == LOADING_VECTOR);
        m_rsp.valid = mem_rsp.valid && (state == LOADING_MATRIX);
    end

    load_v #(
        .TILE_ELEMS(TILE_ELEMS),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_load_v (
        .clk     (clk),
        .rst     (rst),
        .start   (v_start),
        .addr    (cmd_q.addr),
        .length  (cmd_q.length_or_cols),
        .issue_ok(v_issue_ok),
        .req     (v_req),
        .rsp     (v_rsp),
        .wr_valid(v_wr_valid),
        .wr_index(v_wr_index),
        .wr_tile (v_wr_tile),
        .finished(v_finished)
    );

    load_m #(
        .TILE_ELEMS(TILE_ELEMS),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_load_m (
        .clk     (clk),
        .rst     (rst),
        .start   (m_start),
        .addr    (cmd_q.addr),
        .rows    (cmd_q.rows),
        .cols    (cmd_q.length_or_cols),
        .issue_ok(m_issue_ok),
        .req     (m_req),
        .rsp     (m_rsp),
        .wr_valid(m_wr_valid),
        .wr_index(m_wr_index),
        .wr_tile (m_wr_tile),
        .finished(m_finished)
    );

    // Request and write mux, writes tagged with the latched destination
    always_comb begin
        mem_req = '0;
        buf_wr  = '0;
        case (state)
            LOADING_VECTOR: begin
                mem_req      = v_req;
                buf_wr.en    = v_wr_valid;
                buf_wr.index = v_wr_index;
                buf_wr.tile  = v_wr_tile;
            end
            LOADING_MATRIX: begin
                mem_req      = m_req;
                buf_wr.en    = m_wr_valid;
                buf_wr.index = m_wr_index;
                buf_wr.tile  = m_wr_tile;
            end
            default: ;
        endcase
        buf_wr.buffer_id = cmd_q.dest_buffer;
    end

    // Credit count, down per request, up per returned credit
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= CRED_W'(MEM_CREDITS);
        end else begin
            credits <= credits - CRED_W'(mem_req.valid) + CRED_W'(mem_credit);
        end
    end

    // Command held for the engines while the load runs
    always_ff @(posedge clk) begin
        if (cmd_valid && !busy) begin
            cmd_q <= cmd;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            v_start <= 1'b0;
            m_start <= 1'b0;
            done    <= 1'b0;
            cmd_err <= 1'b0;
        end else begin
            v_start <= 1'b0;
            m_start <= 1'b0;
            done    <= 1'b0;
            cmd_err <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd_valid) begin
                        case (cmd.opcode)
                            OP_LOAD_V: begin
                                v_start <= 1'b1;
                                state   <= LOADING_VECTOR;
                            end
                            OP_LOAD_M: begin
                                m_start <= 1'b1;
                                state   <= LOADING_MATRIX;
                            end
                            // Unknown opcode, no memory traffic
                            default: state <= COMPLETE;
                        endcase
                    end
                end
                LOADING_VECTOR: begin
                    if (v_finished) begin
                        done  <= 1'b1;
                        state <= IDLE;
                    end
                end
                LOADING_MATRIX: begin
                    if (m_finished) begin
                        done  <= 1'b1;
                        state <= IDLE;
                    end
                end
                // Reject path, reports the error with done
                COMPLETE: begin
                    done    <= 1'b1;
                    cmd_err <= 1'b1;
                    state   <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== hdl/tile_buffer.sv ====
/*
 * On-chip tile storage
 *   NUM_BUFFERS buffers of BUF_DEPTH tiles each
 *   One write port taking effect at the clock edge
 *   One registered read port, zero for out of range reads
 */
`timescale 1ns/1ps

module tile_buffer import load_pkg::*; #(
    parameter int NUM_BUFFERS = 4,
    parameter int BUF_DEPTH   = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  buf_wr_t                 wr,
    input  logic                    rd_en,
    input  logic [BUF_ID_WIDTH-1:0] rd_id,
    input  logic [INDEX_WIDTH-1:0]  rd_index,
    output tile_u                   rd_data
);

    // Select widths into the array
    localparam int ID_BITS  = (NUM_BUFFERS > 1) ? $clog2(NUM_BUFFERS) : 1;
    localparam int IDX_BITS = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;

    tile_u               mem [NUM_BUFFERS][BUF_DEPTH];
    logic                wr_in_range;
    logic                rd_in_range;
    logic [ID_BITS-1:0]  wr_id;
    logic [IDX_BITS-1:0] wr_idx;
    logic [ID_BITS-1:0]  rd_id_sel;
    logic [IDX_BITS-1:0] rd_idx_sel;

    // Range checks on the full incoming width
    assign wr_in_range = (int'(wr.buffer_id) < NUM_BUFFERS) && (int'(wr.index) < BUF_DEPTH);
    assign rd_in_range = (int'(rd_id) < NUM_BUFFERS) && (int'(rd_index) < BUF_DEPTH);

    // Truncated selects, only used once in range
    assign wr_id      = wr.buffer_id[ID_BITS-1:0];
    assign wr_idx     = wr.index[IDX_BITS-1:0];
    assign rd_id_sel  = rd_id[ID_BITS-1:0];
    assign rd_idx_sel = rd_index[IDX_BITS-1:0];

    // Out of range writes are dropped
    always_ff @(posedge clk) begin
        if (wr.en && wr_in_range) begin
            mem[wr_id][wr_idx] <= wr.tile;
        end
    end

    // Read data valid the cycle after rd_en
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_data <= '0;
        end else if (rd_en) begin
            if (rd_in_range) begin
                rd_data <= mem[rd_id_sel][rd_idx_sel];
            end else begin
                rd_data <= '0;
            end
        end
    end

endmodule

// ==== hdl/load_top.sv ====
/*
 * Load stage top level
 *   Command control with both load engines
 *   Tile buffer bank with host read port
 */
`timescale 1ns/1ps

module load_top import load_pkg::*; #(
    parameter int DATA_WIDTH  = load_pkg::DATA_WIDTH,
    parameter int TILE_WIDTH  = load_pkg::TILE_WIDTH,
    parameter int ADDR_WIDTH  = load_pkg::ADDR_WIDTH,
    parameter int MEM_CREDITS = 4,
    parameter int NUM_BUFFERS = 4,
    parameter int BUF_DEPTH   = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    // Command interface
    input  logic                    cmd_valid,
    input  load_cmd_t               cmd,
    output logic                    busy,
    output logic                    done,
    output logic                    cmd_err,
    // DRAM read port
    output mem_req_t                mem_req,
    input  logic                    mem_credit,
    input  mem_rsp_t                mem_rsp,
    // Buffer read port
    input  logic                    buf_rd_en,
    input  logic [BUF_ID_WIDTH-1:0] buf_rd_id,
    input  logic [INDEX_WIDTH-1:0]  buf_rd_index,
    output tile_u                   buf_rd_data
);

    localparam int TILE_ELEMS = TILE_WIDTH / DATA_WIDTH;

    buf_wr_t buf_wr;

    load_execution #(
        .MEM_CREDITS(MEM_CREDITS),
        .TILE_ELEMS (TILE_ELEMS),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_load_execution (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .done      (done),
        .cmd_err   (cmd_err),
        .mem_req   (mem_req),
        .mem_credit(mem_credit),
        .mem_rsp   (mem_rsp),
        .buf_wr    (buf_wr)
    );

    tile_buffer #(
        .NUM_BUFFERS(NUM_BUFFERS),
        .BUF_DEPTH  (BUF_DEPTH)
    ) u_tile_buffer (
        .clk     (clk),
        .rst     (rst),
        .wr      (buf_wr),
        .rd_en   (buf_rd_en),
        .rd_id   (buf_rd_id),
        .rd_index(buf_rd_index),
        .rd_data (buf_rd_data)
    );

endmodule

// ==== testbench/tb_load_top.sv ====
/*
 * Load stage testbench
 *   Clock, reset and command driver
 *   DRAM model with random latency and credit return
 *   Reference tile function and buffer readback checks
 */
`timescale 1ns/1ps

module tb_load_top import load_pkg::*; ();

    localparam int W           = TILE_WIDTH;
    localparam int MEM_CREDITS = 4;
    localparam int NUM_BUFFERS = 4;
    localparam int BUF_DEPTH   = 16;
    // Extra credit delay while the memory holds credits back
    localparam int HOLD_CYCLES = 12;
    // 14 commands of at most 16 tiles, stalls and readback stay far below this
    localparam int MAX_CYCLES  = 20000;

    logic                    clk;
    logic                    rst;
    logic                    cmd_valid;
    load_cmd_t               cmd;
    logic                    busy;
    logic                    done;
    logic                    cmd_err;
    mem_req_t                mem_req;
    logic                    mem_credit;
    mem_rsp_t                mem_rsp;
    logic                    buf_rd_en;
    logic [BUF_ID_WIDTH-1:0] buf_rd_id;
    logic [INDEX_WIDTH-1:0]  buf_rd_index;
    tile_u                   buf_rd_data;

    // Cycle count, also the time base of the DRAM model
    int cyc;
    // DRAM model state
    logic [ADDR_WIDTH-1:0] rsp_addr_q[$];
    int                    rsp_due_q[$];
    int                    cred_due_q[$];
    int                    total_reqs;
    int                    outstanding;
    int                    max_out;
    logic                  hold_credits;

    load_top #(
        .MEM_CREDITS(MEM_CREDITS),
        .NUM_BUFFERS(NUM_BUFFERS),
        .BUF_DEPTH  (BUF_DEPTH)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .busy        (busy),
        .done        (done),
        .cmd_err     (cmd_err),
        .mem_req     (mem_req),
        .mem_credit  (mem_credit),
        .mem_rsp     (mem_rsp),
        .buf_rd_en   (buf_rd_en),
        .buf_rd_id   (buf_rd_id),
        .buf_rd_index(buf_rd_index),
        .buf_rd_data (buf_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Hash of the tile address, 32 bits at a time
    function automatic logic [W-1:0] mem_word(input logic [ADDR_WIDTH-1:0] addr);
        logic [W-1:0] t;
        logic [31:0]  x;
        for (int w = 0; w < W / 32; w++) begin
            x = ({8'h00, addr} * 32'h9e3779b1) ^ (32'(w + 1) * 32'h85ebca6b);
            x = x ^ (x >> 15);
            x = x * 32'hc2b2ae35;
            x = x ^ (x >> 13);
            t[w*32 +: 32] = x;
        end
        return t;
    endfunction

    // Expected buffer tile for one index of a load
    function automatic logic [W-1:0] expected_tile(input opcode_t op,
                                                   input logic [ADDR_WIDTH-1:0] addr,
                                                   input int shape, input int idx);
        logic [W-1:0] t;
        t = mem_word(addr + ADDR_WIDTH'(idx));
        for (int e = 0; e < TILE_ELEMS; e++) begin
            // Vector tail past length, matrix columns at or past cols
            if ((op == OP_LOAD_V && idx * TILE_ELEMS + e >= shape) ||
                (op == OP_LOAD_M && e >= shape)) begin
                t[e*DATA_WIDTH +: DATA_WIDTH] = '0;
            end
        end
        return t;
    endfunction

    function automatic int tile_count(input load_cmd_t c);
        if (c.opcode == OP_LOAD_V) begin
            return (int'(c.length_or_cols) + TILE_ELEMS - 1) / TILE_ELEMS;
        end else if (c.opcode == OP_LOAD_M) begin
            return int'(c.rows);
        end
        return 0;
    endfunction

    function automatic load_cmd_t make_cmd(input opcode_t op, input int buf_id,
                                           input int addr, input int shape, input int rows);
        load_cmd_t c;
        c.opcode         = op;
        c.dest_buffer    = BUF_ID_WIDTH'(buf_id);
        c.addr           = ADDR_WIDTH'(addr);
        c.length_or_cols = 10'(shape);
        c.rows           = 10'(rows);
        return c;
    endfunction

    task automatic check(input string name, input logic [W-1:0] got, input logic [W-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    // DRAM model, requests seen at negedge, responses and credits driven after the edge
    initial begin
        int due;
        mem_rsp     = '0;
        mem_credit  = 1'b0;
        total_reqs  = 0;
        outstanding = 0;
        max_out     = 0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (mem_credit) outstanding--;
                if (mem_req.valid) begin
                    outstanding++;
                    total_reqs++;
                    // In order responses, one per cycle at most
                    due = cyc + int'($urandom_range(1, 4));
                    if (rsp_due_q.size() > 0 && due <= rsp_due_q[$]) due = rsp_due_q[$] + 1;
                    rsp_due_q.push_back(due);
                    rsp_addr_q.push_back(mem_req.addr);
                    due = cyc + 1 + int'($urandom_range(0, 3)) + (hold_credits ? HOLD_CYCLES : 0);
                    if (cred_due_q.size() > 0 && due <= cred_due_q[$]) due = cred_due_q[$] + 1;
                    cred_due_q.push_back(due);
                end
                if (outstanding > max_out) max_out = outstanding;
                check("outstanding_within_credits", W'(outstanding <= MEM_CREDITS), W'(1));
            end
            @(posedge clk);
            #2;
            mem_rsp    = '0;
            mem_credit = 1'b0;
            if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
                void'(rsp_due_q.pop_front());
                mem_rsp.valid    = 1'b1;
                mem_rsp.data.raw = mem_word(rsp_addr_q.pop_front());
            end
            if (cred_due_q.size() > 0 && cred_due_q[0] <= cyc) begin
                void'(cred_due_q.pop_front());
                mem_credit = 1'b1;
            end
        end
    end

    // Timeout
    initial begin
        cyc = 0;
        while (cyc < MAX_CYCLES) begin
            @(posedge clk);
            cyc++;
        end
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

    // Issue one command and wait for done
    task automatic run_cmd(input load_cmd_t c, input int exp_reqs, input logic exp_err);
        int reqs_before;
        @(posedge clk);
        #2;
        cmd_valid   = 1'b1;
        cmd         = c;
        reqs_before = total_reqs;
        @(posedge clk);
        #2;
        cmd_valid = 1'b0;
        @(negedge clk);
        check("busy", W'(busy), W'(1));
        check("done", W'(done), W'(0));
        while (!done) @(negedge clk);
        check("cmd_err", W'(cmd_err), W'(exp_err));
        check("request_count", W'(total_reqs - reqs_before), W'(exp_reqs));
    endtask

    task automatic read_tile(input logic [BUF_ID_WIDTH-1:0] id, input int idx,
                             output logic [W-1:0] data);
        @(posedge clk);
        #2;
        buf_rd_en    = 1'b1;
        buf_rd_id    = id;
        buf_rd_index = INDEX_WIDTH'(idx);
        @(posedge clk);
        #2;
        buf_rd_en = 1'b0;
        @(negedge clk);
        data = buf_rd_data.raw;
    endtask

    task automatic verify_buffer(input load_cmd_t c);
        logic [W-1:0] got;
        for (int i = 0; i < tile_count(c); i++) begin
            read_tile(c.dest_buffer, i, got);
            check($sformatf("buf_rd_data[%0d][%0d]", c.dest_buffer, i), got,
                  expected_tile(c.opcode, c.addr, int'(c.length_or_cols), i));
        end
    endtask

    initial begin
        load_cmd_t v_cmd;
        load_cmd_t m_cmd;
        load_cmd_t c;
        void'($urandom(32'h346e));
        rst          = 1'b1;
        cmd_valid    = 1'b0;
        cmd          = '0;
        buf_rd_en    = 1'b0;
        buf_rd_id    = '0;
        buf_rd_index = '0;
        hold_credits = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check("done", W'(done), W'(0));
        check("busy", W'(busy), W'(0));
        check("cmd_err", W'(cmd_err), W'(0));
        check("mem_req.valid", W'(mem_req.valid), W'(0));

        // Vector of 70 elements, last tile keeps elements 0 to 5
        v_cmd = make_cmd(OP_LOAD_V, 1, 24'h000100, 70, 0);
        run_cmd(v_cmd, 3, 1'b0);
        verify_buffer(v_cmd);

        // Matrix of 5 rows by 10 columns
        m_cmd = make_cmd(OP_LOAD_M, 2, 24'h004000, 10, 5);
        run_cmd(m_cmd, 5, 1'b0);
        verify_buffer(m_cmd);

        // Illegal opcode aimed at buffer 2, nothing fetched or written
        c = make_cmd(opcode_t'(5'd7), 2, 24'h00beef, 32, 4);
        run_cmd(c, 0, 1'b1);
        verify_buffer(m_cmd);
        verify_buffer(v_cmd);

        // Long vector with credits held back, issue must stall at the credit limit
        hold_credits = 1'b1;
        c = make_cmd(OP_LOAD_V, 3, 24'h020000, 480, 0);
        run_cmd(c, 15, 1'b0);
        hold_credits = 1'b0;
        verify_buffer(c);
        check("max_outstanding", W'(max_out), W'(MEM_CREDITS));

        // Random legal commands
        for (int n = 0; n < 10; n++) begin
            if ($urandom_range(0, 1) == 0) begin
                c = make_cmd(OP_LOAD_V, int'($urandom_range(0, NUM_BUFFERS - 1)),
                             int'($urandom), int'($urandom_range(0, BUF_DEPTH * TILE_ELEMS)),
                             int'($urandom_range(0, 1023)));
            end else begin
                c = make_cmd(OP_LOAD_M, int'($urandom_range(0, NUM_BUFFERS - 1)),
                             int'($urandom), int'($urandom_range(0, 40)),
                             int'($urandom_range(0, BUF_DEPTH)));
            end
            run_cmd(c, tile_count(c), 1'b0);
            verify_buffer(c);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== verilog.f ====
hdl/load_pkg.sv
hdl/load_v.sv
hdl/load_m.sv
hdl/load_execution.sv
hdl/tile_buffer.sv
hdl/load_top.sv
testbench/tb_load_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the load stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_load_top -Mdir obj_dir -f verilog.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_load_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The pass line decides the result
if echo "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
else
    echo "Pass line not found in simulation output"
    exit 1
fi
